// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f sources.f --top-module lsu_tb -o lsu_sim
	./obj_dir/lsu_sim | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/lsu.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu (
   input  logic                    clk,
   input  logic                    arst_n,
   // pipeline, execute stage
   input  logic                    valid_e,
   input  lsu_pkg::lsu_op_e        lsu_op,
   input  logic [`LSU_GRLEN-1:0]   base,
   input  logic [`LSU_GRLEN-1:0]   offset,
   input  logic [`LSU_GRLEN-1:0]   wdata,
   input  logic [`LSU_RD_BITS-1:0] ecl_lsu_rd_e,
   input  logic                    ecl_lsu_wen_e,
   output logic                    lsu_addr_finish,
   output logic                    lsu_ecl_ale_e,
   output logic [`LSU_GRLEN-1:0]   lsu_csr_badv_e,
   // memory
   output logic                    data_req,
   output logic [`LSU_GRLEN-1:0]   data_addr,
   output logic                    data_wr,
   output logic [3:0]              data_wstrb,
   output logic [`LSU_GRLEN-1:0]   data_wdata,
   output logic                    data_ll,
   output logic                    data_sc,
   input  logic                    data_addr_ok,
   input  logic                    data_data_ok,
   input  logic [`LSU_GRLEN-1:0]   data_rdata,
   input  logic                    data_scsucceed,
   // pipeline, memory stage
   output logic                    lsu_finish_m,
   output logic [`LSU_GRLEN-1:0]   read_result_m,
   output logic [`LSU_RD_BITS-1:0] lsu_ecl_rd_m,
   output logic                    lsu_ecl_wen_m,
   output logic                    lsu_ale_m
);

   import lsu_pkg::*;

   logic       q_full;
   logic       q_empty;
   logic       push;
   logic       pop;
   lsu_track_t push_entry;
   lsu_track_t head;

   lsu_issue u_issue (
      .clk             (clk),
      .arst_n          (arst_n),
      .valid_e         (valid_e),
      .lsu_op          (lsu_op),
      .base            (base),
      .offset          (offset),
      .wdata           (wdata),
      .ecl_lsu_rd_e    (ecl_lsu_rd_e),
      .ecl_lsu_wen_e   (ecl_lsu_wen_e),
      .data_addr_ok    (data_addr_ok),
      .q_full          (q_full),
      .data_req        (data_req),
      .data_addr       (data_addr),
      .data_wr         (data_wr),
      .data_wstrb      (data_wstrb),
      .data_wdata      (data_wdata),
      .data_ll         (data_ll),
      .data_sc         (data_sc),
      .lsu_addr_finish (lsu_addr_finish),
      .lsu_ecl_ale_e   (lsu_ecl_ale_e),
      .lsu_csr_badv_e  (lsu_csr_badv_e),
      .push            (push),
      .push_entry      (push_entry)
   );

   lsu_track_fifo #(
      .DEPTH (`LSU_MAX_OUTSTANDING)
   ) u_track (
      .clk        (clk),
      .arst_n     (arst_n),
      .push       (push),
      .pop        (pop),
      .push_entry (push_entry),
      .full       (q_full),
      .empty      (q_empty),
      .head       (head)
   );

   lsu_writeback u_wb (
      .clk            (clk),
      .arst_n         (arst_n),
      .head           (head),
      .empty          (q_empty),
      .data_data_ok   (data_data_ok),
      .data_scsucceed (data_scsucceed),
      .data_rdata     (data_rdata),
      .pop            (pop),
      .lsu_finish_m   (lsu_finish_m),
      .lsu_ale_m      (lsu_ale_m),
      .read_result_m  (read_result_m),
      .lsu_ecl_rd_m   (lsu_ecl_rd_m),
      .lsu_ecl_wen_m  (lsu_ecl_wen_m)
   );

endmodule

// File: design/lsu_decoder.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_decoder (
   input  lsu_pkg::lsu_op_e   op,
   output lsu_pkg::lsu_size_e size,
   output logic               is_signed,
   output logic               is_load,
   output logic               is_store,
   output logic               is_ll,
   output logic               is_sc
);

   import lsu_pkg::*;

   // plain loads only, ll is reported on its own
   assign is_load   = op inside {LSU_LD_B, LSU_LD_BU, LSU_LD_H, LSU_LD_HU, LSU_LD_W};
   assign is_store  = op inside {LSU_ST_B, LSU_ST_H, LSU_ST_W};
   assign is_ll     = (op == LSU_LL_W);
   assign is_sc     = (op == LSU_SC_W);
   assign is_signed = op inside {LSU_LD_B, LSU_LD_H};

   always_comb begin
      case (op)
         LSU_LD_B,
         LSU_LD_BU,
         LSU_ST_B: begin
            size = LSU_SZ_B;
         end
         LSU_LD_H,
         LSU_LD_HU,
         LSU_ST_H: begin
            size = LSU_SZ_H;
         end
         // word, ll, sc and unused encodings
         default: begin
            size = LSU_SZ_W;
         end
      endcase
   end

endmodule

// File: design/lsu_issue.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_issue (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    valid_e,
   input  lsu_pkg::lsu_op_e        lsu_op,
   input  logic [`LSU_GRLEN-1:0]   base,
   input  logic [`LSU_GRLEN-1:0]   offset,
   input  logic [`LSU_GRLEN-1:0]   wdata,
   input  logic [`LSU_RD_BITS-1:0] ecl_lsu_rd_e,
   input  logic                    ecl_lsu_wen_e,
   input  logic                    data_addr_ok,
   input  logic                    q_full,
   output logic                    data_req,
   output logic [`LSU_GRLEN-1:0]   data_addr,
   output logic                    data_wr,
   output logic [3:0]              data_wstrb,
   output logic [`LSU_GRLEN-1:0]   data_wdata,
   output logic                    data_ll,
   output logic                    data_sc,
   output logic                    lsu_addr_finish,
   output logic                    lsu_ecl_ale_e,
   output logic [`LSU_GRLEN-1:0]   lsu_csr_badv_e,
   output logic                    push,
   output lsu_pkg::lsu_track_t     push_entry
);

   import lsu_pkg::*;

   lsu_size_e             size;
   logic                  is_store;
   logic                  is_ll;
   logic                  is_sc;
   logic [`LSU_GRLEN-1:0] addr;
   logic                  ale;

   lsu_decoder u_dec (
      .op        (lsu_op),
      .size      (size),
      .is_signed (),
      .is_load   (),
      .is_store  (is_store),
      .is_ll     (is_ll),
      .is_sc     (is_sc)
   );

   assign addr = base + offset;

   // ll and sc decode as word size
   assign ale = ((size == LSU_SZ_H) && addr[0]) ||
                ((size == LSU_SZ_W) && (addr[1:0] != 2'b00));

   assign lsu_ecl_ale_e  = valid_e & ale;
   assign lsu_csr_badv_e = addr;

   // misaligned ops never reach memory but still take a queue slot
   assign data_req        = valid_e & ~ale & ~q_full;
   assign lsu_addr_finish = valid_e & ~q_full & (ale | data_addr_ok);

   assign data_addr = addr;
   assign data_wr   = is_store | is_sc;
   assign data_ll   = is_ll;
   assign data_sc   = is_sc;

   always_comb begin
      case (size)
         LSU_SZ_B: begin
            data_wstrb = 4'b0001 << addr[1:0];
            data_wdata = {4{wdata[7:0]}};
         end
         LSU_SZ_H: begin
            data_wstrb = 4'b0011 << addr[1:0];
            data_wdata = {2{wdata[15:0]}};
         end
         default: begin
            data_wstrb = 4'b1111;
            data_wdata = wdata;
         end
      endcase
      // loads carry no strobes
      if (!data_wr) begin
         data_wstrb = 4'b0000;
      end
   end

   assign push       = lsu_addr_finish;
   assign push_entry = '{op: lsu_op, byte_off: addr[1:0], rd: ecl_lsu_rd_e,
                         wen: ecl_lsu_wen_e, ale: ale};

   // a stalled request must be held by the pipeline until memory takes it
   a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
      data_req && !data_addr_ok |=> data_req && $stable(data_addr) && $stable(data_wr) &&
      $stable(data_wstrb) && $stable(data_wdata) && $stable(data_ll) && $stable(data_sc));

endmodule

// File: design/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

   // operation codes driven by the pipeline
   typedef enum logic [`LSU_OP_BITS-1:0] {
      LSU_LD_B,
      LSU_LD_BU,
      LSU_LD_H,
      LSU_LD_HU,
      LSU_LD_W,
      LSU_ST_B,
      LSU_ST_H,
      LSU_ST_W,
      LSU_LL_W,
      LSU_SC_W
   } lsu_op_e;

   // access size
   typedef enum logic [1:0] {
      LSU_SZ_B,
      LSU_SZ_H,
      LSU_SZ_W
   } lsu_size_e;

   // one accepted operation waiting for its reply
   typedef struct packed {
      lsu_op_e                 op;
      logic [1:0]              byte_off;
      logic [`LSU_RD_BITS-1:0] rd;
      logic                    wen;
      // misaligned, never sent to memory
      logic                    ale;
   } lsu_track_t;

endpackage

// File: design/lsu_track_fifo.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_track_fifo #(
   parameter int DEPTH = `LSU_MAX_OUTSTANDING
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                push,
   input  logic                pop,
   input  lsu_pkg::lsu_track_t push_entry,
   output logic                full,
   output logic                empty,
   output lsu_pkg::lsu_track_t head
);

   import lsu_pkg::*;

   localparam int AW = $clog2(DEPTH);

   lsu_track_t    mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else begin
         if (push) begin
            mem[wr_ptr] <= push_entry;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // simultaneous push and pop leaves the count unchanged
         case ({push, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign full  = (count == (AW + 1)'(DEPTH));
   assign empty = (count == '0);
   assign head  = mem[rd_ptr];

   a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
      push |-> !full);

   a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
      pop |-> !empty);

endmodule

// File: design/lsu_writeback.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_writeback (
   input  logic                    clk,
   input  logic                    arst_n,
   input  lsu_pkg::lsu_track_t     head,
   input  logic                    empty,
   input  logic                    data_data_ok,
   input  logic                    data_scsucceed,
   input  logic [`LSU_GRLEN-1:0]   data_rdata,
   output logic                    pop,
   output logic                    lsu_finish_m,
   output logic                    lsu_ale_m,
   output logic [`LSU_GRLEN-1:0]   read_result_m,
   output logic [`LSU_RD_BITS-1:0] lsu_ecl_rd_m,
   output logic                    lsu_ecl_wen_m
);

   import lsu_pkg::*;

   lsu_size_e   size;
   logic        is_signed;
   logic        is_load;
   logic        is_ll;
   logic        is_sc;
   logic [7:0]  byte_lane;
   logic [15:0] half_lane;

   lsu_decoder u_dec (
      .op        (head.op),
      .size      (size),
      .is_signed (is_signed),
      .is_load   (is_load),
      .is_store  (),
      .is_ll     (is_ll),
      .is_sc     (is_sc)
   );

   // a misaligned head retires on its own, no reply is coming for it
   assign pop          = ~empty & (head.ale | data_data_ok);
   assign lsu_finish_m = pop;

   assign lsu_ale_m     = head.ale;
   assign lsu_ecl_rd_m  = head.rd;
   assign lsu_ecl_wen_m = head.wen & ~head.ale;

   always_comb begin
      case (head.byte_off)
         2'd0: byte_lane = data_rdata[7:0];
         2'd1: byte_lane = data_rdata[15:8];
         2'd2: byte_lane = data_rdata[23:16];
         default: byte_lane = data_rdata[31:24];
      endcase
   end

   assign half_lane = head.byte_off[1] ? data_rdata[31:16] : data_rdata[15:0];

   always_comb begin
      read_result_m = '0;
      if (!head.ale) begin
         if (is_sc) begin
            read_result_m = {{(`LSU_GRLEN-1){1'b0}}, data_scsucceed};
         end else if (is_load || is_ll) begin
            case (size)
               LSU_SZ_B: read_result_m = {{(`LSU_GRLEN-8){is_signed & byte_lane[7]}}, byte_lane};
               LSU_SZ_H: read_result_m = {{(`LSU_GRLEN-16){is_signed & half_lane[15]}}, half_lane};
               default: read_result_m = data_rdata;
            endcase
         end
      end
   end

   // replies only belong to entries that were sent to memory
   a_reply_matches_head: assert property (@(posedge clk) disable iff (!arst_n)
      data_data_ok |-> !empty && !head.ale);

endmodule

// File: include/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data and address width
`define LSU_GRLEN 32

// width of the operation code from the pipeline
`define LSU_OP_BITS 4

// destination register index width
`define LSU_RD_BITS 5

// operations accepted but not yet finished
`define LSU_MAX_OUTSTANDING 4

`endif

// File: sources.f
+incdir+include
design/lsu_pkg.sv
design/lsu_decoder.sv
design/lsu_issue.sv
design/lsu_track_fifo.sv
design/lsu_writeback.sv
design/lsu.sv
testbench/lsu_mem_model.sv
testbench/lsu_tb.sv

// File: testbench/lsu_mem_model.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_mem_model #(
   parameter int SEED = 1
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  data_req,
   input  logic [`LSU_GRLEN-1:0] data_addr,
   input  logic                  data_wr,
   input  logic [3:0]            data_wstrb,
   input  logic [`LSU_GRLEN-1:0] data_wdata,
   input  logic                  data_ll,
   input  logic                  data_sc,
   output logic                  data_addr_ok,
   output logic                  data_data_ok,
   output logic [`LSU_GRLEN-1:0] data_rdata,
   output logic                  data_scsucceed
);

   logic [7:0]  mem [256];
   logic [31:0] rdata_q [$];
   logic        sc_q [$];
   int          due_q [$];
   int          cyc;
   int          seed;
   logic        resv_valid;
   logic [7:0]  resv_word;

   initial begin
      seed           = SEED;
      cyc            = 0;
      resv_valid     = 1'b0;
      resv_word      = 8'h00;
      data_addr_ok   = 1'b0;
      data_data_ok   = 1'b0;
      data_rdata     = '0;
      data_scsucceed = 1'b0;
      for (int i = 0; i < 256; i++) begin
         mem[i] = 8'(i * 7 + 60);
      end
   end

   // requests are served at acceptance, the reply is delayed 1 to 4 cycles
   always @(posedge clk) begin
      logic [7:0] w;
      logic       succ;
      w = {data_addr[7:2], 2'b00};
      if (arst_n && data_req && data_addr_ok) begin
         succ = 1'b0;
         if (data_sc) begin
            succ = resv_valid && (resv_word == w);
            resv_valid = 1'b0;
         end else if (data_wr && resv_word == w) begin
            resv_valid = 1'b0;
         end
         if (data_ll) begin
            resv_valid = 1'b1;
            resv_word  = w;
         end
         if (data_wr && (!data_sc || succ)) begin
            for (int k = 0; k < 4; k++) begin
               if (data_wstrb[k]) begin
                  mem[8'(w + k)] = data_wdata[8*k +: 8];
               end
            end
         end
         rdata_q.push_back({mem[8'(w + 3)], mem[8'(w + 2)], mem[8'(w + 1)], mem[w]});
         sc_q.push_back(succ);
         due_q.push_back(cyc + 1 + int'({$random(seed)} % 4));
      end
      cyc++;
   end

   always @(negedge clk) begin
      data_addr_ok = arst_n && (({$random(seed)} % 4) != 0);
      data_data_ok = 1'b0;
      if (arst_n && due_q.size() > 0 && cyc >= due_q[0]) begin
         data_data_ok   = 1'b1;
         data_rdata     = rdata_q.pop_front();
         data_scsucceed = sc_q.pop_front();
         void'(due_q.pop_front());
      end
   end

endmodule

// File: testbench/lsu_tb.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_tb;

   import lsu_pkg::*;

   localparam int NUM_OPS    = 400;
   localparam int MAX_CYCLES = 6000;

   logic        clk;
   logic        arst_n;
   logic        valid_e;
   lsu_op_e     lsu_op;
   logic [31:0] base;
   logic [31:0] offset;
   logic [31:0] wdata;
   logic [4:0]  ecl_lsu_rd_e;
   logic        ecl_lsu_wen_e;
   logic        lsu_addr_finish;
   logic        lsu_ecl_ale_e;
   logic [31:0] lsu_csr_badv_e;
   logic        data_req;
   logic [31:0] data_addr;
   logic        data_wr;
   logic [3:0]  data_wstrb;
   logic [31:0] data_wdata;
   logic        data_ll;
   logic        data_sc;
   logic        data_addr_ok;
   logic        data_data_ok;
   logic [31:0] data_rdata;
   logic        data_scsucceed;
   logic        lsu_finish_m;
   logic [31:0] read_result_m;
   logic [4:0]  lsu_ecl_rd_m;
   logic        lsu_ecl_wen_m;
   logic        lsu_ale_m;

   int          seed = 32'hfde1;
   int          value_errors = 0;
   int          other_errors = 0;
   int          cycles = 0;
   int          outstanding = 0;
   logic        post_reset = 1'b0;
   logic [7:0]  shadow [256];
   logic        resv_valid = 1'b0;
   logic [7:0]  resv_word = 8'h00;
   logic [31:0] exp_res [$];
   logic [4:0]  exp_rd [$];
   logic        exp_wen [$];
   logic        exp_ale [$];
   logic        prev_stall = 1'b0;
   logic [70:0] prev_fields;

   lsu DUT (.*);

   lsu_mem_model #(.SEED(32'hfde1)) u_mem (.*);

   always #50 clk = ~clk;

   task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      value_errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
   endtask

   task automatic report_other(input string what);
      other_errors++;
      $display("error: %s", what);
   endtask

   function automatic logic misaligned(input lsu_op_e op, input logic [1:0] lo);
      if (op inside {LSU_LD_H, LSU_LD_HU, LSU_ST_H}) begin
         return lo[0];
      end
      if (op inside {LSU_LD_B, LSU_LD_BU, LSU_ST_B}) begin
         return 1'b0;
      end
      return lo != 2'b00;
   endfunction

   // protocol checks on the rising edge
   always @(posedge clk) begin
      logic [31:0] a;
      logic [7:0]  w;
      logic        mis;
      logic [3:0]  strb;
      logic [31:0] swd;
      logic [31:0] res;
      logic        succ;
      a   = base + offset;
      w   = {a[7:2], 2'b00};
      mis = misaligned(lsu_op, a[1:0]);
      if (!arst_n || post_reset) begin
         assert (!data_req && !lsu_addr_finish && !lsu_finish_m)
            else report_other("handshake outputs active around reset");
      end
      post_reset <= !arst_n;
      if (prev_stall) begin
         assert (data_req && prev_fields == {data_addr, data_wr, data_wstrb, data_wdata,
                                             data_ll, data_sc})
            else report_other("stalled request changed before memory took it");
      end
      if (arst_n && data_req && !data_addr_ok) begin
         assert (!lsu_addr_finish) else report_other("operation accepted during a stall");
      end
      prev_stall  = arst_n && data_req && !data_addr_ok;
      prev_fields = {data_addr, data_wr, data_wstrb, data_wdata, data_ll, data_sc};
      if (arst_n && valid_e) begin
         assert (lsu_ecl_ale_e == mis) else report_value("ale_e", 32'(mis), 32'(lsu_ecl_ale_e));
         assert (lsu_csr_badv_e == a) else report_value("badv", a, lsu_csr_badv_e);
         if (mis) begin
            assert (!data_req) else report_other("misaligned operation sent to memory");
         end
      end
      if (arst_n && lsu_finish_m) begin
         if (exp_res.size() == 0) begin
            report_other("operation finished with nothing outstanding");
         end else begin
            res = exp_res.pop_front();
            assert (read_result_m == res) else report_value("result", res, read_result_m);
            res = 32'(exp_rd.pop_front());
            assert (lsu_ecl_rd_m == res[4:0]) else report_value("rd", res, 32'(lsu_ecl_rd_m));
            res = 32'(exp_wen.pop_front());
            assert (lsu_ecl_wen_m == res[0]) else report_value("wen", res, 32'(lsu_ecl_wen_m));
            res = 32'(exp_ale.pop_front());
            assert (lsu_ale_m == res[0]) else report_value("ale_m", res, 32'(lsu_ale_m));
         end
      end
      if (arst_n && lsu_addr_finish) begin
         res  = '0;
         succ = 1'b0;
         if (!mis) begin
            case (lsu_op)
               LSU_LD_B: res = {{24{shadow[a[7:0]][7]}}, shadow[a[7:0]]};
               LSU_LD_BU: res = {24'h0, shadow[a[7:0]]};
               LSU_LD_H: res = {{16{shadow[8'(a[7:0] + 1)][7]}},
                                shadow[8'(a[7:0] + 1)], shadow[a[7:0]]};
               LSU_LD_HU: res = {16'h0, shadow[8'(a[7:0] + 1)], shadow[a[7:0]]};
               LSU_LD_W, LSU_LL_W: res = {shadow[8'(w + 3)], shadow[8'(w + 2)],
                                          shadow[8'(w + 1)], shadow[w]};
               default: res = '0;
            endcase
            strb = (lsu_op == LSU_ST_B) ? 4'b0001 << a[1:0] :
                   (lsu_op == LSU_ST_H) ? 4'b0011 << a[1:0] : 4'b1111;
            swd  = (lsu_op == LSU_ST_B) ? {wdata[7:0], wdata[7:0], wdata[7:0], wdata[7:0]} :
                   (lsu_op == LSU_ST_H) ? {wdata[15:0], wdata[15:0]} : wdata;
            if (lsu_op == LSU_SC_W) begin
               succ       = resv_valid && resv_word == w;
               res        = 32'(succ);
               resv_valid = 1'b0;
            end
            if (lsu_op inside {LSU_ST_B, LSU_ST_H, LSU_ST_W}) begin
               assert (data_wstrb == strb) else report_value("wstrb", 32'(strb), 32'(data_wstrb));
               assert (data_wdata == swd) else report_value("wdata", swd, data_wdata);
               if (resv_word == w) begin
                  resv_valid = 1'b0;
               end
            end
            if (lsu_op inside {LSU_ST_B, LSU_ST_H, LSU_ST_W} || succ) begin
               for (int k = 0; k < 4; k++) begin
                  if (strb[k]) begin
                     shadow[8'(w + k)] = swd[8*k +: 8];
                  end
               end
            end
            if (lsu_op == LSU_LL_W) begin
               resv_valid = 1'b1;
               resv_word  = w;
            end
         end
         exp_res.push_back(res);
         exp_rd.push_back(ecl_lsu_rd_e);
         exp_wen.push_back(ecl_lsu_wen_e && !mis);
         exp_ale.push_back(mis);
      end
      outstanding = outstanding + int'(arst_n && lsu_addr_finish) - int'(arst_n && lsu_finish_m);
      assert (outstanding <= `LSU_MAX_OUTSTANDING)
         else report_other("more than four operations outstanding");
   end

   // drives one operation and holds it until the LSU takes it
   task automatic issue_op(input lsu_op_e op, input logic [31:0] b, input logic [31:0] off,
                           input logic [31:0] wd, input logic [4:0] rd, input logic wen);
      logic        taken;
      logic [31:0] a;
      taken = 1'b0;
      a     = b + off;
      @(negedge clk);
      valid_e       = 1'b1;
      lsu_op        = op;
      base          = b;
      offset        = off;
      wdata         = wd;
      ecl_lsu_rd_e  = rd;
      ecl_lsu_wen_e = wen;
      while (!taken) begin
         @(posedge clk);
         taken = lsu_addr_finish;
      end
      // the pipeline issues nothing behind an address exception until it retires
      if (misaligned(op, a[1:0])) begin
         @(negedge clk);
         valid_e = 1'b0;
         while (outstanding != 0) begin
            @(negedge clk);
         end
      end
   endtask

   task automatic idle_cycle();
      @(negedge clk);
      valid_e = 1'b0;
   endtask

   task automatic random_op();
      lsu_op_e     op;
      logic [31:0] off;
      op  = lsu_op_e'(4'({$random(seed)} % 10));
      off = $random(seed) & 32'h7;
      if (({$random(seed)} % 4) != 0) begin
         off = off & 32'h4;
      end
      issue_op(op, $random(seed) & 32'hf8, off, $random(seed), 5'($random(seed)),
               1'($random(seed)));
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         report_other("timeout, operations did not finish in time");
         $display("errors: value=%0d other=%0d", value_errors, other_errors);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      clk           = 1'b0;
      arst_n        = 1'b0;
      valid_e       = 1'b0;
      lsu_op        = LSU_LD_W;
      base          = '0;
      offset        = '0;
      wdata         = '0;
      ecl_lsu_rd_e  = '0;
      ecl_lsu_wen_e = 1'b0;
      for (int i = 0; i < 256; i++) begin
         shadow[i] = 8'(i * 7 + 60);
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      // ll then sc on the same word, then sc without a reservation
      issue_op(LSU_LL_W, 32'h40, 32'h0, 32'h0, 5'd1, 1'b1);
      issue_op(LSU_SC_W, 32'h40, 32'h0, 32'hcafef00d, 5'd2, 1'b1);
      issue_op(LSU_LD_W, 32'h3c, 32'h4, 32'h0, 5'd3, 1'b1);
      issue_op(LSU_SC_W, 32'h80, 32'h0, 32'h12345678, 5'd4, 1'b1);
      issue_op(LSU_LD_W, 32'h80, 32'h0, 32'h0, 5'd5, 1'b1);
      issue_op(LSU_ST_H, 32'h43, 32'h0, 32'hffff, 5'd6, 1'b1);
      for (int n = 6; n < NUM_OPS; n++) begin
         if (({$random(seed)} % 8) == 0) begin
            idle_cycle();
         end
         random_op();
      end
      idle_cycle();
      while (outstanding != 0) begin
         @(negedge clk);
      end
      @(negedge clk);
      $display("errors: value=%0d other=%0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
